/* gpio_cfg.svh */
// Pad count, board pin index map and register word addresses, included by RTL and testbench
`ifndef GPIO_CFG_SVH
`define GPIO_CFG_SVH

// Number of GPIO pads on the board
`define GPIO_N_PADS 12

// Pin index map, one bit of the pad vector per named pin
`define PIN_LED        0
`define PIN_UART_TX    1
`define PIN_UART_RX    2
`define PIN_FLASH_MISO 3
`define PIN_FLASH_MOSI 4
`define PIN_FLASH_SCLK 5
`define PIN_FLASH_CS   6
`define PIN_DPAD_U     7
`define PIN_DPAD_D     8
`define PIN_DPAD_L     9
`define PIN_DPAD_R     10
`define PIN_BTN_A      11

// Register word addresses
// Sized to match the 4-bit bus address
`define GPIO_ADDR_OUT     4'd0
`define GPIO_ADDR_OE      4'd1
`define GPIO_ADDR_IN      4'd2
`define GPIO_ADDR_OUT_SET 4'd3
`define GPIO_ADDR_OUT_CLR 4'd4
`define GPIO_ADDR_OUT_TOG 4'd5
`define GPIO_ADDR_OE_SET  4'd6
`define GPIO_ADDR_OE_CLR  4'd7

// Addresses 8 to 15 are unmapped

`endif

/* gpio_pkg.sv */
// Shared types of the GPIO subsystem, imported by every module that needs them
`default_nettype none

`include "gpio_cfg.svh"

package gpio_pkg;

	// One bit per pad, indexed by the PIN_ map
	typedef logic [`GPIO_N_PADS-1:0] pad_vec_t;

	// Bus data word, pad bits sit in the low bits
	typedef logic [15:0] reg_word_t;

	// Register word address
	typedef logic [3:0] reg_addr_t;

	// Register operation produced by the decoder
	typedef enum logic [2:0] {
		OP_NONE,
		OP_OUT_WRITE,
		OP_OE_WRITE,
		OP_OUT_SET,
		OP_OUT_CLR,
		OP_OUT_TOG,
		OP_OE_SET,
		OP_OE_CLR
	} reg_op_t;

endpackage

`default_nettype wire

/* gpio_reg_decode.sv */
// Register address decoder, turns bus strobes and address into one operation and a read select
`default_nettype none
`timescale 1ns/10ps

`include "gpio_cfg.svh"

module gpio_reg_decode
	import gpio_pkg::*;
(
	input  wire       clk_sys,
	input  wire       reset,

	input  reg_addr_t bus_addr,
	input  wire       bus_wen,
	input  wire       bus_ren,

	output reg_op_t   op,
	output logic      rd_en,
	output reg_addr_t rd_sel
);

// Write decode
// Purely combinational so the register update lands on the strobe edge
always_comb begin
	op = OP_NONE;
	if (bus_wen) begin
		case (bus_addr)
			`GPIO_ADDR_OUT:     op = OP_OUT_WRITE;
			`GPIO_ADDR_OE:      op = OP_OE_WRITE;
			`GPIO_ADDR_OUT_SET: op = OP_OUT_SET;
			`GPIO_ADDR_OUT_CLR: op = OP_OUT_CLR;
			`GPIO_ADDR_OUT_TOG: op = OP_OUT_TOG;
			`GPIO_ADDR_OE_SET:  op = OP_OE_SET;
			`GPIO_ADDR_OE_CLR:  op = OP_OE_CLR;
			// IN is read-only, unmapped addresses are ignored too
			default:            op = OP_NONE;
		endcase
	end
end

// Read path, address selects the word in the register block
assign rd_en = bus_ren;
assign rd_sel = bus_addr;

// The bus master never issues a read and a write in the same cycle
a_no_rw_overlap: assert property (
	@(posedge clk_sys) disable iff (reset)
	!(bus_wen && bus_ren)
) else $error("bus_wen and bus_ren high together");

endmodule

`default_nettype wire

/* gpio_regs.sv */
// GPIO register block, keeps OUT and OE, synchronizes pad inputs and returns bus read data
`default_nettype none
`timescale 1ns/10ps

`include "gpio_cfg.svh"

module gpio_regs
	import gpio_pkg::*;
(
	input  wire       clk_sys,
	input  wire       reset,

	input  reg_op_t   op,
	input  reg_word_t bus_wdata,
	input  wire       rd_en,
	input  reg_addr_t rd_sel,

	input  pad_vec_t  pad_in,
	output pad_vec_t  pad_out,
	output pad_vec_t  pad_oe,

	output reg_word_t bus_rdata
);

pad_vec_t out_q;
pad_vec_t oe_q;
pad_vec_t wr_bits;

// Two-flop synchronizer for the asynchronous pin levels
pad_vec_t in_meta;
pad_vec_t in_sync;

reg_word_t rd_word;

// Only the low bits of the bus word map onto pads
assign wr_bits = bus_wdata[`GPIO_N_PADS-1:0];

// OUT register
always_ff @(posedge clk_sys) begin
	if (reset) begin
		out_q <= '0;
	end else begin
		case (op)
			OP_OUT_WRITE: out_q <= wr_bits;
			OP_OUT_SET:   out_q <= out_q | wr_bits;
			OP_OUT_CLR:   out_q <= out_q & ~wr_bits;
			OP_OUT_TOG:   out_q <= out_q ^ wr_bits;
			default:      out_q <= out_q;
		endcase
	end
end

// OE register, no toggle operation here
always_ff @(posedge clk_sys) begin
	if (reset) begin
		oe_q <= '0;
	end else begin
		case (op)
			OP_OE_WRITE: oe_q <= wr_bits;
			OP_OE_SET:   oe_q <= oe_q | wr_bits;
			OP_OE_CLR:   oe_q <= oe_q & ~wr_bits;
			default:     oe_q <= oe_q;
		endcase
	end
end

assign pad_out = out_q;
assign pad_oe = oe_q;

// Input synchronizer
// New pin level shows in IN two edges after it changes
always_ff @(posedge clk_sys) begin
	in_meta <= pad_in;
	in_sync <= in_meta;
end

// Read select, the set/clear/toggle addresses are write-only
always_comb begin
	case (rd_sel)
		`GPIO_ADDR_OUT: rd_word = reg_word_t'(out_q);
		`GPIO_ADDR_OE:  rd_word = reg_word_t'(oe_q);
		`GPIO_ADDR_IN:  rd_word = reg_word_t'(in_sync);
		default:        rd_word = '0;
	endcase
end

// Read data holds until the next read strobe
always_ff @(posedge clk_sys) begin
	if (reset) begin
		bus_rdata <= '0;
	end else if (rd_en) begin
		bus_rdata <= rd_word;
	end
end

// All pads come out of reset released
a_oe_clear_after_reset: assert property (
	@(posedge clk_sys)
	reset |=> (pad_oe == '0)
) else $error("pad_oe not cleared after reset");

endmodule

`default_nettype wire

/* gpio_pads.sv */
// Tristate pad cells for the named board pins and the status LED map
`default_nettype none
`timescale 1ns/10ps

`include "gpio_cfg.svh"

module gpio_pads
	import gpio_pkg::*;
(
	input  pad_vec_t   pad_out,
	input  pad_vec_t   pad_oe,
	output pad_vec_t   pad_in,

	inout  wire        uart_tx,
	inout  wire        uart_rx,
	inout  wire        flash_miso,
	inout  wire        flash_mosi,
	inout  wire        flash_sclk,
	inout  wire        flash_cs,
	inout  wire        dpad_u,
	inout  wire        dpad_d,
	inout  wire        dpad_l,
	inout  wire        dpad_r,
	inout  wire        btn_a,
	inout  wire        led_pad,

	output logic [7:0] led
);

// Output drivers
// A pin is driven only while its OE bit is set, otherwise released
assign led_pad    = pad_oe[`PIN_LED]        ? pad_out[`PIN_LED]        : 1'bz;
assign uart_tx    = pad_oe[`PIN_UART_TX]    ? pad_out[`PIN_UART_TX]    : 1'bz;
assign uart_rx    = pad_oe[`PIN_UART_RX]    ? pad_out[`PIN_UART_RX]    : 1'bz;
assign flash_miso = pad_oe[`PIN_FLASH_MISO] ? pad_out[`PIN_FLASH_MISO] : 1'bz;
assign flash_mosi = pad_oe[`PIN_FLASH_MOSI] ? pad_out[`PIN_FLASH_MOSI] : 1'bz;
assign flash_sclk = pad_oe[`PIN_FLASH_SCLK] ? pad_out[`PIN_FLASH_SCLK] : 1'bz;
assign flash_cs   = pad_oe[`PIN_FLASH_CS]   ? pad_out[`PIN_FLASH_CS]   : 1'bz;
assign dpad_u     = pad_oe[`PIN_DPAD_U]     ? pad_out[`PIN_DPAD_U]     : 1'bz;
assign dpad_d     = pad_oe[`PIN_DPAD_D]     ? pad_out[`PIN_DPAD_D]     : 1'bz;
assign dpad_l     = pad_oe[`PIN_DPAD_L]     ? pad_out[`PIN_DPAD_L]     : 1'bz;
assign dpad_r     = pad_oe[`PIN_DPAD_R]     ? pad_out[`PIN_DPAD_R]     : 1'bz;
assign btn_a      = pad_oe[`PIN_BTN_A]      ? pad_out[`PIN_BTN_A]      : 1'bz;

// Input receivers, always see the pin level whoever drives it
assign pad_in[`PIN_LED]        = led_pad;
assign pad_in[`PIN_UART_TX]    = uart_tx;
assign pad_in[`PIN_UART_RX]    = uart_rx;
assign pad_in[`PIN_FLASH_MISO] = flash_miso;
assign pad_in[`PIN_FLASH_MOSI] = flash_mosi;
assign pad_in[`PIN_FLASH_SCLK] = flash_sclk;
assign pad_in[`PIN_FLASH_CS]   = flash_cs;
assign pad_in[`PIN_DPAD_U]     = dpad_u;
assign pad_in[`PIN_DPAD_D]     = dpad_d;
assign pad_in[`PIN_DPAD_L]     = dpad_l;
assign pad_in[`PIN_DPAD_R]     = dpad_r;
assign pad_in[`PIN_BTN_A]      = btn_a;

// Status LEDs
// UART lines idle high, so their LEDs are inverted to light on activity
assign led = {
	~pad_out[`PIN_UART_TX],
	~pad_in[`PIN_UART_RX],
	pad_in[`PIN_DPAD_U],
	pad_in[`PIN_DPAD_D],
	pad_in[`PIN_DPAD_L],
	pad_in[`PIN_DPAD_R],
	pad_in[`PIN_BTN_A],
	pad_out[`PIN_LED] & pad_oe[`PIN_LED]
};

endmodule

`default_nettype wire

/* gpio_top.sv */
// GPIO subsystem top level, joins the register bus to the named board pins and status LEDs
`default_nettype none
`timescale 1ns/10ps

module gpio_top
	import gpio_pkg::*;
(
	input  wire        clk_sys,
	input  wire        reset,

	// Register bus
	input  reg_addr_t  bus_addr,
	input  reg_word_t  bus_wdata,
	input  wire        bus_wen,
	input  wire        bus_ren,
	output reg_word_t  bus_rdata,

	// Board pins
	inout  wire        uart_tx,
	inout  wire        uart_rx,
	inout  wire        flash_miso,
	inout  wire        flash_mosi,
	inout  wire        flash_sclk,
	inout  wire        flash_cs,
	inout  wire        dpad_u,
	inout  wire        dpad_d,
	inout  wire        dpad_l,
	inout  wire        dpad_r,
	inout  wire        btn_a,
	inout  wire        led_pad,

	output logic [7:0] led
);

reg_op_t   op;
logic      rd_en;
reg_addr_t rd_sel;

pad_vec_t  pad_out;
pad_vec_t  pad_oe;
pad_vec_t  pad_in;

gpio_reg_decode decode (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.bus_addr (bus_addr),
	.bus_wen  (bus_wen),
	.bus_ren  (bus_ren),
	.op       (op),
	.rd_en    (rd_en),
	.rd_sel   (rd_sel)
);

gpio_regs regs (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.op        (op),
	.bus_wdata (bus_wdata),
	.rd_en     (rd_en),
	.rd_sel    (rd_sel),
	.pad_in    (pad_in),
	.pad_out   (pad_out),
	.pad_oe    (pad_oe),
	.bus_rdata (bus_rdata)
);

// Pad ring and LED map
gpio_pads pads (
	.pad_out    (pad_out),
	.pad_oe     (pad_oe),
	.pad_in     (pad_in),
	.uart_tx    (uart_tx),
	.uart_rx    (uart_rx),
	.flash_miso (flash_miso),
	.flash_mosi (flash_mosi),
	.flash_sclk (flash_sclk),
	.flash_cs   (flash_cs),
	.dpad_u     (dpad_u),
	.dpad_d     (dpad_d),
	.dpad_l     (dpad_l),
	.dpad_r     (dpad_r),
	.btn_a      (btn_a),
	.led_pad    (led_pad),
	.led        (led)
);

endmodule

`default_nettype wire

/* tb_gpio.sv */
// Directed testbench for gpio_top, drives the register bus and board pins and checks the responses
`default_nettype none
`timescale 1ns/10ps

`include "gpio_cfg.svh"

module tb_gpio
	import gpio_pkg::*;
();

// Rough cycle counts per test, the run is stopped at twice their sum
localparam int TEST_CYCLES = 12 + 8 + 10 + 64 + 28 + 28 + 24;
localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

logic      clk_sys;
logic      reset;
reg_addr_t bus_addr;
reg_word_t bus_wdata;
logic      bus_wen;
logic      bus_ren;
reg_word_t bus_rdata;
logic [7:0] led;

wire uart_tx;
wire uart_rx;
wire flash_miso;
wire flash_mosi;
wire flash_sclk;
wire flash_cs;
wire dpad_u;
wire dpad_d;
wire dpad_l;
wire dpad_r;
wire btn_a;
wire led_pad;

// Per-pin board drivers and the level seen on every pin
pad_vec_t drv_en;
pad_vec_t drv_val;
pad_vec_t pin_level;

// Reference model of OUT and OE
pad_vec_t model_out;
pad_vec_t model_oe;

logic [31:0] rng_state = 32'h7e9c_ee98;
int error_count;
int check_count;
int cycle_count;

assign led_pad    = drv_en[`PIN_LED]        ? drv_val[`PIN_LED]        : 1'bz;
assign uart_tx    = drv_en[`PIN_UART_TX]    ? drv_val[`PIN_UART_TX]    : 1'bz;
assign uart_rx    = drv_en[`PIN_UART_RX]    ? drv_val[`PIN_UART_RX]    : 1'bz;
assign flash_miso = drv_en[`PIN_FLASH_MISO] ? drv_val[`PIN_FLASH_MISO] : 1'bz;
assign flash_mosi = drv_en[`PIN_FLASH_MOSI] ? drv_val[`PIN_FLASH_MOSI] : 1'bz;
assign flash_sclk = drv_en[`PIN_FLASH_SCLK] ? drv_val[`PIN_FLASH_SCLK] : 1'bz;
assign flash_cs   = drv_en[`PIN_FLASH_CS]   ? drv_val[`PIN_FLASH_CS]   : 1'bz;
assign dpad_u     = drv_en[`PIN_DPAD_U]     ? drv_val[`PIN_DPAD_U]     : 1'bz;
assign dpad_d     = drv_en[`PIN_DPAD_D]     ? drv_val[`PIN_DPAD_D]     : 1'bz;
assign dpad_l     = drv_en[`PIN_DPAD_L]     ? drv_val[`PIN_DPAD_L]     : 1'bz;
assign dpad_r     = drv_en[`PIN_DPAD_R]     ? drv_val[`PIN_DPAD_R]     : 1'bz;
assign btn_a      = drv_en[`PIN_BTN_A]      ? drv_val[`PIN_BTN_A]      : 1'bz;

assign pin_level = {btn_a, dpad_r, dpad_l, dpad_d, dpad_u, flash_cs, flash_sclk,
	flash_mosi, flash_miso, uart_rx, uart_tx, led_pad};

gpio_top uut (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.bus_addr   (bus_addr),
	.bus_wdata  (bus_wdata),
	.bus_wen    (bus_wen),
	.bus_ren    (bus_ren),
	.bus_rdata  (bus_rdata),
	.uart_tx    (uart_tx),
	.uart_rx    (uart_rx),
	.flash_miso (flash_miso),
	.flash_mosi (flash_mosi),
	.flash_sclk (flash_sclk),
	.flash_cs   (flash_cs),
	.dpad_u     (dpad_u),
	.dpad_d     (dpad_d),
	.dpad_l     (dpad_l),
	.dpad_r     (dpad_r),
	.btn_a      (btn_a),
	.led_pad    (led_pad),
	.led        (led)
);

initial begin
	clk_sys = 1'b0;
	forever #2 clk_sys = ~clk_sys;
end

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] s;
	s = x;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

function automatic reg_word_t rand_word();
	rng_state = xorshift32(rng_state);
	return rng_state[15:0];
endfunction

// Random level for every board pin
function automatic pad_vec_t rand_pad_levels();
	reg_word_t w;
	w = rand_word();
	return w[`GPIO_N_PADS-1:0];
endfunction

task automatic check_equal(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	check_count++;
	if (expected !== actual) begin
		error_count++;
		$display("[ERROR] %s: expected 'h%0h, actual 'h%0h", name, expected, actual);
	end
endtask

// Register rules, applied to the model only
task automatic apply_to_model(input reg_addr_t addr, input reg_word_t data);
	pad_vec_t bits;
	bits = data[`GPIO_N_PADS-1:0];
	case (addr)
		`GPIO_ADDR_OUT:     model_out = bits;
		`GPIO_ADDR_OE:      model_oe = bits;
		`GPIO_ADDR_OUT_SET: model_out = model_out | bits;
		`GPIO_ADDR_OUT_CLR: model_out = model_out & ~bits;
		`GPIO_ADDR_OUT_TOG: model_out = model_out ^ bits;
		`GPIO_ADDR_OE_SET:  model_oe = model_oe | bits;
		`GPIO_ADDR_OE_CLR:  model_oe = model_oe & ~bits;
		default:            model_out = model_out;
	endcase
endtask

// Pin level: enabled pads show OUT, released pads show the board driver
function automatic pad_vec_t expected_level();
	return (model_out & model_oe) | (drv_val & ~model_oe);
endfunction

function automatic logic [7:0] expected_led();
	pad_vec_t lvl;
	lvl = expected_level();
	return {~model_out[`PIN_UART_TX], ~lvl[`PIN_UART_RX], lvl[`PIN_DPAD_U], lvl[`PIN_DPAD_D],
		lvl[`PIN_DPAD_L], lvl[`PIN_DPAD_R], lvl[`PIN_BTN_A],
		model_out[`PIN_LED] & model_oe[`PIN_LED]};
endfunction

// Called and returns on a falling edge
task automatic write_reg(input reg_addr_t addr, input reg_word_t data);
	pad_vec_t oe_before;
	oe_before = model_oe;
	apply_to_model(addr, data);
	// Let go of pins the DUT starts driving at the coming edge
	drv_en = ~(oe_before | model_oe);
	bus_addr = addr;
	bus_wdata = data;
	bus_wen = 1'b1;
	@(negedge clk_sys);
	bus_wen = 1'b0;
	drv_en = ~model_oe;
endtask

task automatic read_reg(input reg_addr_t addr, output reg_word_t data);
	bus_addr = addr;
	bus_ren = 1'b1;
	@(negedge clk_sys);
	bus_ren = 1'b0;
	data = bus_rdata;
endtask

task automatic check_out_oe(input string name);
	reg_word_t rd;
	read_reg(`GPIO_ADDR_OUT, rd);
	check_equal({name, " OUT"}, 32'(model_out), 32'(rd));
	read_reg(`GPIO_ADDR_OE, rd);
	check_equal({name, " OE"}, 32'(model_oe), 32'(rd));
endtask

task automatic reset_state();
	check_equal("reset rdata", 32'h0, 32'(bus_rdata));
	check_out_oe("reset");
	check_equal("reset pins", 32'(drv_val), 32'(pin_level));
	check_equal("reset led", 32'(expected_led()), 32'(led));
	check_equal("reset led bit 7", 32'h1, 32'(led[7]));
	check_equal("reset led bit 0", 32'h0, 32'(led[0]));
endtask

task automatic write_readback();
	write_reg(`GPIO_ADDR_OUT, rand_word());
	write_reg(`GPIO_ADDR_OE, rand_word());
	check_out_oe("write_readback");
	check_equal("write_readback pins", 32'(expected_level()), 32'(pin_level));
endtask

task automatic set_clear_toggle();
	reg_addr_t addr;
	repeat (20) begin
		addr = `GPIO_ADDR_OUT_SET + reg_addr_t'(rand_word() % 16'd5);
		write_reg(addr, rand_word());
		check_out_oe("set_clear_toggle");
	end
endtask

task automatic input_path();
	reg_word_t rd;
	repeat (4) begin
		write_reg(`GPIO_ADDR_OUT, rand_word());
		write_reg(`GPIO_ADDR_OE, rand_word());
		drv_val = rand_pad_levels();
		repeat (3) @(negedge clk_sys);
		read_reg(`GPIO_ADDR_IN, rd);
		check_equal("input_path IN", 32'(expected_level()), 32'(rd));
	end
endtask

task automatic led_map();
	repeat (8) begin
		write_reg(`GPIO_ADDR_OUT, rand_word());
		write_reg(`GPIO_ADDR_OE, rand_word());
		drv_val = rand_pad_levels();
		@(negedge clk_sys);
		check_equal("led_map", 32'(expected_led()), 32'(led));
	end
endtask

task automatic undefined_addresses();
	reg_word_t rd;
	for (int a = 8; a < 16; a++) begin
		write_reg(reg_addr_t'(a), rand_word());
	end
	write_reg(`GPIO_ADDR_IN, rand_word());
	check_out_oe("undefined_addresses");
	for (int a = 8; a < 16; a++) begin
		read_reg(reg_addr_t'(a), rd);
		check_equal("undefined_addresses read", 32'h0, 32'(rd));
	end
endtask

initial begin
	cycle_count = 0;
	while (cycle_count < TIMEOUT_CYCLES) begin
		@(posedge clk_sys);
		cycle_count++;
	end
	$display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
	$display("Verification failed");
	$finish;
end

initial begin
	reset = 1'b1;
	bus_addr = '0;
	bus_wdata = '0;
	bus_wen = 1'b0;
	bus_ren = 1'b0;
	model_out = '0;
	model_oe = '0;
	error_count = 0;
	check_count = 0;
	drv_en = '1;
	drv_val = rand_pad_levels();
	repeat (10) @(negedge clk_sys);
	reset = 1'b0;
	@(negedge clk_sys);

	reset_state();
	write_readback();
	set_clear_toggle();
	input_path();
	led_map();
	undefined_addresses();

	$display("Checks: %0d, errors: %0d", check_count, error_count);
	if (error_count == 0) begin
		$display("Verification passed");
	end else begin
		$display("Verification failed");
	end
	$finish;
end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
gpio_pkg.sv
gpio_reg_decode.sv
gpio_regs.sv
gpio_pads.sv
gpio_top.sv
tb_gpio.sv

/* Makefile */
# Verilator build and run for the GPIO subsystem testbench

TOP = tb_gpio

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): files.f gpio_cfg.svh gpio_pkg.sv gpio_reg_decode.sv gpio_regs.sv \
		gpio_pads.sv gpio_top.sv tb_gpio.sv
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

# Pass only when the pass message appears in the simulation output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
